// ==== build.f ====
src/soc_pkg.sv
src/btn_master.sv
src/soc_bus.sv
src/mem_slave.sv
src/led_slave.sv
src/soc_top.sv
bench/tb_soc.sv

// ==== bench/tb_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc;
    import soc_pkg::*;

    logic              sys_clk;
    logic              rst_n;
    logic [3:0]        btn;
    logic              host_req_valid;
    logic              host_req_ready;
    logic              host_req_write;
    logic [addr_w-1:0] host_req_addr;
    logic [data_w-1:0] host_req_wdata;
    logic [strb_w-1:0] host_req_strb;
    logic              host_resp_valid;
    logic              host_resp_ready;
    logic [data_w-1:0] host_resp_rdata;
    logic [1:0]        host_resp_code;
    logic [3:0]        led;

    logic [31:0] rng = 32'hbeef_65bd;
    logic [31:0] mem_model [mem_words];
    logic [31:0] led_model;
    logic [7:0]  used [8];   // word indices with known contents
    int          errors = 0;
    int          test_start;
    int          tests = 0;

    soc_top i_dut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // byte lanes with a strobe bit take the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[8*b +: 8] = wdata[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == test_start)
            $display("test %s: ok", name);
        else
            $display("test %s: FAILED with %0d errors", name, errors - test_start);
    endtask

    // called and returns 1 ns after a rising edge
    task automatic host_access(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb,
                               output logic [31:0] rdata, output logic [1:0] code);
        bus_addr_u a;
        int        n;
        int        lat;
        a.flat         = addr;
        host_req_valid = 1'b1;
        host_req_write = write;
        host_req_addr  = addr;
        host_req_wdata = wdata;
        host_req_strb  = strb;
        n = 0;
        while (!host_req_ready) begin
            @(posedge sys_clk);
            #1;
            n++;
            if (n > 50)
                abort_on_timeout("host_req_ready");
        end
        @(posedge sys_clk);   // accepted on this edge
        #1;
        host_req_valid = 1'b0;
        lat = 0;
        while (!host_resp_valid) begin
            check_value(host_req_ready, 0, "req_ready while busy");
            @(posedge sys_clk);
            #1;
            lat++;
            if (lat > 50)
                abort_on_timeout("host_resp_valid");
        end
        check_value(lat, (a.f.sel == mem_sel || a.f.sel == led_sel) ? 3 : 2,
                    "response latency");
        rdata = host_resp_rdata;
        code  = host_resp_code;
        if (host_resp_ready) begin
            @(posedge sys_clk);
            #1;
        end
    endtask

    initial begin : stimulus
        logic [31:0] rd;
        logic [1:0]  code;
        logic [31:0] r;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [3:0]  sel;
        logic [3:0]  press;
        logic [7:0]  idx;
        int          hold;
        int          n;
        rst_n           = 1'b0;
        btn             = 4'd0;
        host_req_valid  = 1'b0;
        host_req_write  = 1'b0;
        host_req_addr   = '0;
        host_req_wdata  = '0;
        host_req_strb   = '0;
        host_resp_ready = 1'b1;
        repeat (2) @(posedge sys_clk);
        #1;
        rst_n = 1'b1;

        test_start = errors;
        check_value(led, 0, "led after reset");
        check_value(host_resp_valid, 0, "resp_valid after reset");
        check_value(host_req_ready, 0, "req_ready in first cycle after reset");
        host_access(1'b0, led_start, 0, 0, rd, code);
        check_value(rd, 0, "led register after reset");
        check_value(code, resp_okay, "led read code");
        led_model = '0;
        report_test("reset");

        test_start = errors;
        for (int i = 0; i < 8; i++) begin
            r       = next_rand();
            used[i] = r[7:0];
            data    = next_rand();
            host_access(1'b1, {mem_sel, 18'd0, used[i], 2'b00}, data, 4'hf, rd, code);
            mem_model[used[i]] = data;
        end
        for (int i = 0; i < 16; i++) begin
            r    = next_rand();
            idx  = used[r[2:0]];
            data = next_rand();
            r    = next_rand();
            strb = r[3:0];
            host_access(1'b1, {mem_sel, r[27:10], idx, 2'b00}, data, strb, rd, code);
            check_value(code, resp_okay, "mem write code");
            mem_model[idx] = merge_bytes(mem_model[idx], data, strb);
        end
        for (int i = 0; i < 8; i++) begin
            r = next_rand();   // random bits above 9 alias to the same word
            host_access(1'b0, {mem_sel, r[27:10], used[i], 2'b00}, 0, 0, rd, code);
            check_value(rd, mem_model[used[i]], "mem read");
            check_value(code, resp_okay, "mem read code");
        end
        report_test("memory");

        test_start = errors;
        for (int i = 0; i < 4; i++) begin
            data = next_rand();
            r    = next_rand();
            host_access(1'b1, {led_sel, r[31:4]}, data, r[3:0], rd, code);
            led_model = merge_bytes(led_model, data, r[3:0]);
            check_value(led, led_model[3:0], "led pins");
            r = next_rand();
            host_access(1'b0, {led_sel, r[27:0]}, 0, 0, rd, code);
            check_value(rd, led_model, "led register read");
            check_value(code, resp_okay, "led read code");
        end
        report_test("led");

        test_start = errors;
        for (int i = 0; i < 3; i++) begin
            sel  = (i == 0) ? jtag_sel : (i == 1) ? 4'h3 : 4'hf;
            data = next_rand();
            host_access(1'b1, {sel, 18'd0, used[0], 2'b00}, data, 4'hf, rd, code);
            check_value(code, resp_decerr, "unmapped write code");
            check_value(rd, 0, "unmapped write data");
            host_access(1'b0, {sel, 18'd0, used[0], 2'b00}, 0, 0, rd, code);
            check_value(code, resp_decerr, "unmapped read code");
            check_value(rd, 0, "unmapped read data");
            host_access(1'b0, {mem_sel, 18'd0, used[0], 2'b00}, 0, 0, rd, code);
            check_value(rd, mem_model[used[0]], "memory after unmapped write");
        end
        report_test("decode error");

        test_start = errors;
        r     = next_rand();
        press = r[3:0] | 4'b0001;
        btn   = press;
        n     = 0;
        while (led !== press) begin
            @(posedge sys_clk);
            #1;
            n++;
            if (n > 50)
                abort_on_timeout("led to follow the buttons");
        end
        led_model = {28'd0, press};
        host_access(1'b0, led_start, 0, 0, rd, code);
        check_value(rd, {28'd0, led}, "led read against pins");
        check_value(rd, led_model, "led read after press");
        btn = 4'd0;   // release is not a press
        report_test("button");

        test_start = errors;
        host_resp_ready = 1'b0;
        host_access(1'b0, {mem_sel, 18'd0, used[1], 2'b00}, 0, 0, rd, code);
        check_value(rd, mem_model[used[1]], "read under back-pressure");
        check_value(code, resp_okay, "code under back-pressure");
        r    = next_rand();
        hold = 2 + r[2:0];
        for (int i = 0; i < hold; i++) begin
            @(posedge sys_clk);
            #1;
            check_value(host_resp_valid, 1, "resp_valid held");
            check_value(host_resp_rdata, rd, "rdata held");
            check_value(host_resp_code, code, "code held");
            check_value(host_req_ready, 0, "req_ready under back-pressure");
        end
        host_resp_ready = 1'b1;
        @(posedge sys_clk);
        #1;
        check_value(host_resp_valid, 0, "resp_valid after transfer");
        host_access(1'b0, {mem_sel, 18'd0, used[2], 2'b00}, 0, 0, rd, code);
        check_value(rd, mem_model[used[2]], "read after back-pressure");
        report_test("back-pressure");

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top (
    input  logic                        sys_clk,
    input  logic                        rst_n,
    input  logic [3:0]                  btn,
    // host port
    input  logic                        host_req_valid,
    output logic                        host_req_ready,
    input  logic                        host_req_write,
    input  logic [soc_pkg::addr_w-1:0]  host_req_addr,
    input  logic [soc_pkg::data_w-1:0]  host_req_wdata,
    input  logic [soc_pkg::strb_w-1:0]  host_req_strb,
    output logic                        host_resp_valid,
    input  logic                        host_resp_ready,
    output logic [soc_pkg::data_w-1:0]  host_resp_rdata,
    output logic [1:0]                  host_resp_code,
    output logic [3:0]                  led
);
    import soc_pkg::*;

    // button master side
    logic              b_req_valid;
    logic              b_req_ready;
    logic              b_req_write;
    logic [addr_w-1:0] b_req_addr;
    logic [data_w-1:0] b_req_wdata;
    logic [strb_w-1:0] b_req_strb;
    logic              b_resp_valid;
    logic              b_resp_ready;

    // slave side
    logic              mem_sel_valid;
    logic              mem_rsp_valid;
    logic [data_w-1:0] mem_rsp_rdata;
    logic              led_sel_valid;
    logic              led_rsp_valid;
    logic [data_w-1:0] led_rsp_rdata;
    logic              s_write;
    logic [addr_w-1:0] s_addr;
    logic [data_w-1:0] s_wdata;
    logic [strb_w-1:0] s_strb;

    btn_master i_btn_master (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .btn        (btn),
        .req_ready  (b_req_ready),
        .resp_valid (b_resp_valid),
        .req_valid  (b_req_valid),
        .req_write  (b_req_write),
        .req_addr   (b_req_addr),
        .req_wdata  (b_req_wdata),
        .req_strb   (b_req_strb),
        .resp_ready (b_resp_ready)
    );

    soc_bus i_bus (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .h_req_valid   (host_req_valid),
        .h_req_ready   (host_req_ready),
        .h_req_write   (host_req_write),
        .h_req_addr    (host_req_addr),
        .h_req_wdata   (host_req_wdata),
        .h_req_strb    (host_req_strb),
        .h_resp_valid  (host_resp_valid),
        .h_resp_ready  (host_resp_ready),
        .h_resp_rdata  (host_resp_rdata),
        .h_resp_code   (host_resp_code),
        .b_req_valid   (b_req_valid),
        .b_req_ready   (b_req_ready),
        .b_req_write   (b_req_write),
        .b_req_addr    (b_req_addr),
        .b_req_wdata   (b_req_wdata),
        .b_req_strb    (b_req_strb),
        .b_resp_valid  (b_resp_valid),
        .b_resp_ready  (b_resp_ready),
        .mem_sel_valid (mem_sel_valid),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata),
        .led_sel_valid (led_sel_valid),
        .led_rsp_valid (led_rsp_valid),
        .led_rsp_rdata (led_rsp_rdata),
        .s_write       (s_write),
        .s_addr        (s_addr),
        .s_wdata       (s_wdata),
        .s_strb        (s_strb)
    );

    mem_slave i_mem (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .sel_valid (mem_sel_valid),
        .req_write (s_write),
        .req_addr  (s_addr),
        .req_wdata (s_wdata),
        .req_strb  (s_strb),
        .rsp_valid (mem_rsp_valid),
        .rsp_rdata (mem_rsp_rdata)
    );

    led_slave i_led (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .sel_valid (led_sel_valid),
        .req_write (s_write),
        .req_addr  (s_addr),
        .req_wdata (s_wdata),
        .req_strb  (s_strb),
        .rsp_valid (led_rsp_valid),
        .rsp_rdata (led_rsp_rdata),
        .led       (led)
    );

endmodule

`default_nettype wire

// ==== src/led_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_slave (
    input  logic                        sys_clk,
    input  logic                        rst_n,
    input  logic                        sel_valid,
    input  logic                        req_write,
    input  logic [soc_pkg::addr_w-1:0]  req_addr,
    input  logic [soc_pkg::data_w-1:0]  req_wdata,
    input  logic [soc_pkg::strb_w-1:0]  req_strb,
    output logic                        rsp_valid,
    output logic [soc_pkg::data_w-1:0]  rsp_rdata,
    output logic [3:0]                  led
);
    import soc_pkg::*;

    bus_addr_u         loc;
    logic              hit;
    logic [data_w-1:0] led_q;

    assign loc = req_addr;
    // whole region is one register, offset ignored
    assign hit = sel_valid && (loc.f.sel == led_sel);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            led_q     <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= sel_valid;
            if (hit && req_write) begin
                for (int b = 0; b < strb_w; b++) begin
                    if (req_strb[b])
                        led_q[8*b +: 8] <= req_wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sel_valid)
            rsp_rdata <= req_write ? '0 : led_q;   // old value on a read
    end

    assign led = led_q[3:0];

endmodule

`default_nettype wire

// ==== src/mem_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_slave (
    input  logic                        sys_clk,
    input  logic                        rst_n,
    input  logic                        sel_valid,
    input  logic                        req_write,
    input  logic [soc_pkg::addr_w-1:0]  req_addr,
    input  logic [soc_pkg::data_w-1:0]  req_wdata,
    input  logic [soc_pkg::strb_w-1:0]  req_strb,
    output logic                        rsp_valid,
    output logic [soc_pkg::data_w-1:0]  rsp_rdata
);
    import soc_pkg::*;

    bus_addr_u            loc;
    logic [mem_idx_w-1:0] idx;
    logic [data_w-1:0]    mem [mem_words];

    assign loc = req_addr - mem_start;
    assign idx = loc.f.offset[mem_idx_w+1:2];   // bits above 9 alias

    // byte lane writes
    always_ff @(posedge sys_clk) begin
        if (sel_valid && req_write) begin
            for (int b = 0; b < strb_w; b++) begin
                if (req_strb[b])
                    mem[idx][8*b +: 8] <= req_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sel_valid)
            rsp_rdata <= req_write ? '0 : mem[idx];
    end

    // fixed one cycle answer
    always_ff @(posedge sys_clk) begin
        if (!rst_n)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= sel_valid;
    end

endmodule

`default_nettype wire

// ==== src/soc_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus (
    input  logic                        sys_clk,
    input  logic                        rst_n,
    // host master
    input  logic                        h_req_valid,
    output logic                        h_req_ready,
    input  logic                        h_req_write,
    input  logic [soc_pkg::addr_w-1:0]  h_req_addr,
    input  logic [soc_pkg::data_w-1:0]  h_req_wdata,
    input  logic [soc_pkg::strb_w-1:0]  h_req_strb,
    output logic                        h_resp_valid,
    input  logic                        h_resp_ready,
    output logic [soc_pkg::data_w-1:0]  h_resp_rdata,
    output logic [1:0]                  h_resp_code,
    // button master
    input  logic                        b_req_valid,
    output logic                        b_req_ready,
    input  logic                        b_req_write,
    input  logic [soc_pkg::addr_w-1:0]  b_req_addr,
    input  logic [soc_pkg::data_w-1:0]  b_req_wdata,
    input  logic [soc_pkg::strb_w-1:0]  b_req_strb,
    output logic                        b_resp_valid,
    input  logic                        b_resp_ready,
    // memory slave
    output logic                        mem_sel_valid,
    input  logic                        mem_rsp_valid,
    input  logic [soc_pkg::data_w-1:0]  mem_rsp_rdata,
    // led slave
    output logic                        led_sel_valid,
    input  logic                        led_rsp_valid,
    input  logic [soc_pkg::data_w-1:0]  led_rsp_rdata,
    // shared toward both slaves
    output logic                        s_write,
    output logic [soc_pkg::addr_w-1:0]  s_addr,
    output logic [soc_pkg::data_w-1:0]  s_wdata,
    output logic [soc_pkg::strb_w-1:0]  s_strb
);
    import soc_pkg::*;

    logic [1:0]        state;
    logic              arm_q;       // low for the first cycle out of reset
    logic              gnt_b_q;     // button master owns the transaction
    logic              miss_q;
    logic              write_q;
    bus_addr_u         addr_q;
    logic [data_w-1:0] wdata_q;
    logic [strb_w-1:0] strb_q;
    logic [data_w-1:0] rdata_q;
    logic [1:0]        code_q;
    logic              idle_rdy;
    logic              accept;
    logic              hit_mem;
    logic              hit_led;
    logic              resp_taken;
    logic              slave_done;

    assign idle_rdy = arm_q && (state == bus_idle);

    // host has fixed priority
    assign h_req_ready = idle_rdy;
    assign b_req_ready = idle_rdy && !h_req_valid;
    assign accept      = idle_rdy && (h_req_valid || b_req_valid);

    always_comb begin
        hit_mem = 1'b0;
        hit_led = 1'b0;
        case (addr_q.f.sel)
            mem_sel: hit_mem = 1'b1;
            led_sel: hit_led = 1'b1;
            default: hit_mem = 1'b0;  // jtag and unmapped regions end as decerr
        endcase
    end

    assign slave_done = mem_rsp_valid || led_rsp_valid;
    assign resp_taken = gnt_b_q ? b_resp_ready : h_resp_ready;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state         <= bus_idle;
            arm_q         <= 1'b0;
            gnt_b_q       <= 1'b0;
            miss_q        <= 1'b0;
            mem_sel_valid <= 1'b0;
            led_sel_valid <= 1'b0;
        end else begin
            arm_q         <= 1'b1;
            mem_sel_valid <= 1'b0;   // single cycle pulse
            led_sel_valid <= 1'b0;
            case (state)
                bus_idle: begin
                    if (accept) begin
                        gnt_b_q <= !h_req_valid;
                        state   <= bus_issue;
                    end
                end
                bus_issue: begin
                    mem_sel_valid <= hit_mem;
                    led_sel_valid <= hit_led;
                    miss_q        <= !(hit_mem || hit_led);
                    state         <= bus_wait;
                end
                bus_wait: begin
                    // a miss answers in the slot a slave would have used
                    if (miss_q || slave_done)
                        state <= bus_respond;
                end
                bus_respond: begin
                    if (resp_taken)
                        state <= bus_idle;
                end
                default: state <= bus_idle;
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            write_q <= h_req_valid ? h_req_write : b_req_write;
            addr_q  <= h_req_valid ? h_req_addr  : b_req_addr;
            wdata_q <= h_req_valid ? h_req_wdata : b_req_wdata;
            strb_q  <= h_req_valid ? h_req_strb  : b_req_strb;
        end
        if (state == bus_wait && (miss_q || slave_done)) begin
            if (miss_q)
                rdata_q <= '0;
            else
                rdata_q <= mem_rsp_valid ? mem_rsp_rdata : led_rsp_rdata;
            code_q <= miss_q ? resp_decerr : resp_okay;
        end
    end

    assign s_write = write_q;
    assign s_addr  = addr_q;
    assign s_wdata = wdata_q;
    assign s_strb  = strb_q;

    // response goes back to the owner only
    assign h_resp_valid = (state == bus_respond) && !gnt_b_q;
    assign b_resp_valid = (state == bus_respond) && gnt_b_q;
    assign h_resp_rdata = rdata_q;
    assign h_resp_code  = code_q;

endmodule

`default_nettype wire

// ==== src/btn_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module btn_master (
    input  logic                        sys_clk,
    input  logic                        rst_n,
    input  logic [3:0]                  btn,
    input  logic                        req_ready,
    input  logic                        resp_valid,
    output logic                        req_valid,
    output logic                        req_write,
    output logic [soc_pkg::addr_w-1:0]  req_addr,
    output logic [soc_pkg::data_w-1:0]  req_wdata,
    output logic [soc_pkg::strb_w-1:0]  req_strb,
    output logic                        resp_ready
);
    import soc_pkg::*;

    logic [3:0] btn_meta;
    logic [3:0] btn_sync;
    logic [3:0] btn_last;   // previous synced value for edge detect
    logic       busy;       // accepted, response not back yet
    logic       press;
    logic       launch;

    assign press  = |(btn_sync & ~btn_last);
    assign launch = press && !req_valid && !busy;

    // two flop synchronizer
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_last <= '0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            btn_last <= btn_sync;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            if (launch) begin
                req_valid <= 1'b1;
            end else if (req_valid && req_ready) begin
                req_valid <= 1'b0;
                busy      <= 1'b1;
            end
            if (busy && resp_valid)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (launch)
            req_wdata <= {{(data_w-4){1'b0}}, btn_sync};  // held until accepted
    end

    // always a full word write to the led register
    assign req_write  = 1'b1;
    assign req_addr   = led_start;
    assign req_strb   = '1;
    assign resp_ready = 1'b1;

endmodule

`default_nettype wire

// ==== src/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = 4;
    localparam int sel_w  = 4;

    // region select values, top nibble of the address
    localparam logic [sel_w-1:0] mem_sel  = 4'd0;
    localparam logic [sel_w-1:0] jtag_sel = 4'd1;   // reserved, nothing behind it
    localparam logic [sel_w-1:0] led_sel  = 4'd2;

    localparam logic [addr_w-1:0] mem_start = 32'h0000_0000;
    localparam logic [addr_w-1:0] led_start = 32'h2000_0000;

    // word memory, index from address bits 9..2
    localparam int mem_words = 256;
    localparam int mem_idx_w = 8;

    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_decerr = 2'd3;

    // bus fsm encoding
    localparam logic [1:0] bus_idle    = 2'd0;
    localparam logic [1:0] bus_issue   = 2'd1;
    localparam logic [1:0] bus_wait    = 2'd2;
    localparam logic [1:0] bus_respond = 2'd3;

    // same word seen flat or as select + offset
    typedef union packed {
        logic [addr_w-1:0] flat;
        struct packed {
            logic [sel_w-1:0]        sel;
            logic [addr_w-sel_w-1:0] offset;
        } f;
    } bus_addr_u;

endpackage

`default_nettype wire
